/* flist.f */
logic/wb_pkg.sv
logic/regfile.sv
logic/csr_regs.sv
logic/exception_commit.sv
logic/ex2_wb_stage.sv
logic/wb_top.sv
testbench/wb_props.sv
testbench/tb_wb_top.sv

/* logic/csr_regs.sv */
`default_nettype none

module csr_regs import wb_pkg::*; (
    input  logic        clk,
    input  logic        aresetn,
    input  csr_wr_t     csr_wr,
    input  logic        flush,
    input  logic        hw_int,
    input  logic [13:0] csr_raddr,
    output logic [31:0] csr_rdata,
    output logic        int_req
);

    logic        crmd_ie;
    logic        hwi_q;
    logic [12:0] estat_is;
    logic [31:0] crmd;
    logic [31:0] estat;
    logic [31:0] era;
    logic [31:0] badv;
    logic [18:0] tlbehi_vppn;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            crmd_ie <= 1'b1;
            hwi_q   <= 1'b0;
        end else begin
            if (flush) begin
                crmd_ie <= 1'b0;  // handler entry masks interrupts
            end
            hwi_q <= hw_int;  // sampled hw line 0
        end
    end

    always_ff @(posedge clk) begin
        if (csr_wr.wen_era) begin
            era <= csr_wr.era;
        end
        if (csr_wr.wen_badv) begin
            badv <= csr_wr.badv;
        end
        if (csr_wr.wen_vppn) begin
            tlbehi_vppn <= csr_wr.vppn;
        end
    end

    // plv stays 0, da and pg not modelled
    assign crmd     = {29'b0, crmd_ie, 2'b00};
    assign estat_is = {10'b0, hwi_q, 2'b00};  // is[2] = hwi0
    assign estat    = {19'b0, estat_is};
    assign int_req  = crmd_ie && (|estat_is);

    always_comb begin
        case (csr_raddr)
            csr_crmd_a:   csr_rdata = crmd;
            csr_estat_a:  csr_rdata = estat;
            csr_era_a:    csr_rdata = era;
            csr_badv_a:   csr_rdata = badv;
            csr_tlbehi_a: csr_rdata = {tlbehi_vppn, 13'b0};  // vppn sits at 31:13
            default:      csr_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/ex2_wb_stage.sv */
`default_nettype none

module ex2_wb_stage import wb_pkg::*; (
    input  logic        clk,
    input  logic        aresetn,
    input  ex2_lane_t   lane0,
    input  ex2_lane_t   lane1,
    input  logic [31:0] quotient,
    input  logic [31:0] remainder,
    input  logic [31:0] dcache_data,
    input  logic [31:0] csr_rdata,
    input  logic        div_ready,
    input  logic        dcache_ready,
    output logic [13:0] csr_raddr,
    output wb_t         wb0,
    output wb_t         wb1,
    output logic        allowin
);

    wb_t         wb0_d;
    wb_t         wb1_d;
    logic [1:0]  we_q;
    logic [4:0]  rd0_q;
    logic [4:0]  rd1_q;
    logic [31:0] data0_q;
    logic [31:0] data1_q;
    logic        stall0;
    logic        stall1;

    // writeback source priority for one lane
    function automatic wb_t pick_wb(
        input ex2_lane_t   ln,
        input logic        csr_port,
        input logic [31:0] csr_data,
        input logic [31:0] quo,
        input logic [31:0] rem,
        input logic        div_rdy,
        input logic [31:0] ld_data,
        input logic        ld_rdy
    );
        wb_t w;
        w.we   = 1'b0;
        w.rd   = ln.rd;
        w.data = '0;
        if (ln.valid) begin
            if (ln.result_valid) begin
                w.we   = 1'b1;
                w.data = ln.result;
            end else if (csr_port && ln.uop.is_csr) begin
                w.we   = 1'b1;
                w.data = csr_data;
            end else if (ln.uop.is_div) begin
                w.we   = div_rdy;
                w.data = ln.uop.cond.div.mod_sel ? rem : quo;
            end else if (ln.uop.is_mem && !ln.uop.cond.mem.is_store) begin
                w.we   = ld_rdy;
                w.data = ld_data;
            end
        end
        return w;
    endfunction

    // divide or load still waiting on its unit
    function automatic logic lane_stall(
        input ex2_lane_t ln,
        input logic      div_rdy,
        input logic      ld_rdy
    );
        logic is_load;
        is_load = ln.uop.is_mem && !ln.uop.cond.mem.is_store;
        return ln.valid && ((ln.uop.is_div && !div_rdy) || (is_load && !ld_rdy));
    endfunction

    always_comb begin
        wb0_d = pick_wb(lane0, 1'b1, csr_rdata, quotient, remainder,
                        div_ready, dcache_data, dcache_ready);
        wb1_d = pick_wb(lane1, 1'b0, csr_rdata, quotient, remainder,
                        div_ready, dcache_data, dcache_ready);
    end

    assign csr_raddr = lane0.uop.csr_addr;  // only lane 0 reads csrs

    assign stall0  = lane_stall(lane0, div_ready, dcache_ready);
    assign stall1  = lane_stall(lane1, div_ready, dcache_ready);
    assign allowin = !(stall0 || stall1);

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            we_q <= 2'b00;
        end else begin
            we_q <= {wb1_d.we, wb0_d.we};
        end
    end

    always_ff @(posedge clk) begin
        rd0_q   <= wb0_d.rd;
        rd1_q   <= wb1_d.rd;
        data0_q <= wb0_d.data;
        data1_q <= wb1_d.data;
    end

    assign wb0 = '{we: we_q[0], rd: rd0_q, data: data0_q};
    assign wb1 = '{we: we_q[1], rd: rd1_q, data: data1_q};

endmodule

`default_nettype wire

/* logic/exception_commit.sv */
`default_nettype none

module exception_commit import wb_pkg::*; (
    input  logic      clk,
    input  logic      aresetn,
    input  exc_info_t exc,
    input  logic      int_req,
    output logic      flush,
    output csr_wr_t   csr_wr
);

    logic        badv_class;
    logic        vppn_class;
    logic        take_int;
    logic        commit;
    logic        commit_q;
    logic        wen_badv_q;
    logic        wen_vppn_q;
    logic [31:0] era_q;
    logic [31:0] badv_q;
    logic [18:0] vppn_q;

    // address-class codes set badv, page-class codes set both
    always_comb begin
        badv_class = 1'b0;
        vppn_class = 1'b0;
        case (exc.ecode)
            exp_pil, exp_pis, exp_pif, exp_pme, exp_ppi, exp_tlbr: begin
                badv_class = 1'b1;
                vppn_class = 1'b1;
            end
            exp_adef, exp_ale: begin
                badv_class = 1'b1;
            end
            default: begin
                badv_class = 1'b0;
                vppn_class = 1'b0;
            end
        endcase
    end

    // ie is cleared one edge after flush, so mask the retake
    assign take_int = int_req && !commit_q;
    assign commit   = exc.flag || take_int;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            commit_q   <= 1'b0;
            wen_badv_q <= 1'b0;
            wen_vppn_q <= 1'b0;
        end else begin
            commit_q   <= commit;
            wen_badv_q <= exc.flag && badv_class;  // interrupts carry no address
            wen_vppn_q <= exc.flag && vppn_class;
        end
    end

    always_ff @(posedge clk) begin
        era_q  <= exc.era;
        badv_q <= exc.badv;
        vppn_q <= exc.badv[18:0];
    end

    assign flush  = commit_q;
    assign csr_wr = '{
        wen_era:  commit_q,
        wen_badv: wen_badv_q,
        wen_vppn: wen_vppn_q,
        era:      era_q,
        badv:     badv_q,
        vppn:     vppn_q
    };

endmodule

`default_nettype wire

/* logic/regfile.sv */
`default_nettype none

module regfile import wb_pkg::*; (
    input  logic        clk,
    input  logic        aresetn,
    input  wb_t         wb0,
    input  wb_t         wb1,
    input  logic [4:0]  raddr,
    output logic [31:0] rdata
);

    logic [31:0] rf [0:31];

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else begin
            if (wb0.we && (wb0.rd != 5'd0)) begin  // r0 never takes a write
                rf[wb0.rd] <= wb0.data;
            end
            // later assignment wins, so lane 1 overrides on same rd
            if (wb1.we && (wb1.rd != 5'd0)) begin
                rf[wb1.rd] <= wb1.data;
            end
        end
    end

    assign rdata = rf[raddr];

endmodule

`default_nettype wire

/* logic/wb_pkg.sv */
`default_nettype none

package wb_pkg;

    // ecode values
    localparam logic [6:0] exp_int  = 7'h00;
    localparam logic [6:0] exp_pil  = 7'h01;
    localparam logic [6:0] exp_pis  = 7'h02;
    localparam logic [6:0] exp_pif  = 7'h03;
    localparam logic [6:0] exp_pme  = 7'h04;
    localparam logic [6:0] exp_ppi  = 7'h07;
    localparam logic [6:0] exp_adef = 7'h08;
    localparam logic [6:0] exp_ale  = 7'h09;
    localparam logic [6:0] exp_sys  = 7'h0b;
    localparam logic [6:0] exp_tlbr = 7'h3f;

    localparam logic [13:0] csr_crmd_a   = 14'h000;
    localparam logic [13:0] csr_estat_a  = 14'h005;
    localparam logic [13:0] csr_era_a    = 14'h006;
    localparam logic [13:0] csr_badv_a   = 14'h007;
    localparam logic [13:0] csr_tlbehi_a = 14'h011;

    // one cond field, read as divide or memory op
    typedef union packed {
        struct packed {
            logic [2:0] rsvd;
            logic       mod_sel;   // 1 = remainder
        } div;
        struct packed {
            logic       rsvd_hi;
            logic       is_store;  // 0 = load
            logic [1:0] rsvd_lo;
        } mem;
    } uop_cond_u;

    typedef struct packed {
        logic        is_csr;
        logic        is_div;
        logic        is_mem;
        uop_cond_u   cond;
        logic [13:0] csr_addr;
    } uop_t;

    typedef struct packed {
        logic        valid;
        logic        result_valid;  // alu result already final
        logic [31:0] result;
        logic [4:0]  rd;
        uop_t        uop;
    } ex2_lane_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

    typedef struct packed {
        logic        flag;
        logic [6:0]  ecode;
        logic [31:0] badv;
        logic [31:0] era;
    } exc_info_t;

    typedef struct packed {
        logic        wen_era;
        logic        wen_badv;
        logic        wen_vppn;
        logic [31:0] era;
        logic [31:0] badv;
        logic [18:0] vppn;
    } csr_wr_t;

endpackage

`default_nettype wire

/* logic/wb_top.sv */
`default_nettype none

module wb_top import wb_pkg::*; (
    input  logic        clk,
    input  logic        aresetn,
    input  ex2_lane_t   lane0,
    input  ex2_lane_t   lane1,
    input  logic [31:0] quotient,
    input  logic [31:0] remainder,
    input  logic        div_ready,
    input  logic [31:0] dcache_data,
    input  logic        dcache_ready,
    input  exc_info_t   exc,
    input  logic        hw_int,
    input  logic [4:0]  rf_raddr,
    output logic        allowin,
    output logic        flush,
    output wb_t         wb0,
    output wb_t         wb1,
    output logic [31:0] rf_rdata
);

    logic [13:0] csr_raddr;
    logic [31:0] csr_rdata;
    logic        int_req;
    csr_wr_t     csr_wr;

    ex2_wb_stage u_stage (
        .clk          (clk),
        .aresetn      (aresetn),
        .lane0        (lane0),
        .lane1        (lane1),
        .quotient     (quotient),
        .remainder    (remainder),
        .dcache_data  (dcache_data),
        .csr_rdata    (csr_rdata),
        .div_ready    (div_ready),
        .dcache_ready (dcache_ready),
        .csr_raddr    (csr_raddr),
        .wb0          (wb0),
        .wb1          (wb1),
        .allowin      (allowin)
    );

    exception_commit u_commit (
        .clk     (clk),
        .aresetn (aresetn),
        .exc     (exc),
        .int_req (int_req),
        .flush   (flush),
        .csr_wr  (csr_wr)
    );

    csr_regs u_csr (
        .clk       (clk),
        .aresetn   (aresetn),
        .csr_wr    (csr_wr),
        .flush     (flush),
        .hw_int    (hw_int),
        .csr_raddr (csr_raddr),
        .csr_rdata (csr_rdata),
        .int_req   (int_req)
    );

    regfile u_rf (
        .clk     (clk),
        .aresetn (aresetn),
        .wb0     (wb0),
        .wb1     (wb1),
        .raddr   (rf_raddr),
        .rdata   (rf_rdata)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the wb_top testbench with verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_wb_top -f flist.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$log"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

/* testbench/tb_wb_top.sv */
`default_nettype none

module tb_wb_top import wb_pkg::*; ();

    typedef enum logic [1:0] {op_alu, op_div, op_mem, op_csr} lane_op_e;

    typedef struct packed {
        ex2_lane_t   l0;
        ex2_lane_t   l1;
        logic [31:0] quo;
        logic [31:0] rem;
        logic [31:0] dcd;
        logic        div_rdy;
        logic        dc_rdy;
        exc_info_t   exc;
        logic        hwi;
        logic [4:0]  chk_rd;
        logic [31:0] exp_data;
        logic [1:0]  exp_we;  // lane 1 then lane 0
        logic        exp_allowin;
        logic        exp_flush;  // flush seen in the two cycles after the row
    } row_t;

    logic        clk;
    logic        aresetn;
    ex2_lane_t   lane0;
    ex2_lane_t   lane1;
    logic [31:0] quotient;
    logic [31:0] remainder;
    logic        div_ready;
    logic [31:0] dcache_data;
    logic        dcache_ready;
    exc_info_t   exc;
    logic        hw_int;
    logic [4:0]  rf_raddr;
    logic        allowin;
    logic        flush;
    wb_t         wb0;
    wb_t         wb1;
    logic [31:0] rf_rdata;

    row_t        rows[$];
    string       names[$];
    row_t        cur;
    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    bit          table_ready;

    wb_top DUT (
        .clk          (clk),
        .aresetn      (aresetn),
        .lane0        (lane0),
        .lane1        (lane1),
        .quotient     (quotient),
        .remainder    (remainder),
        .div_ready    (div_ready),
        .dcache_data  (dcache_data),
        .dcache_ready (dcache_ready),
        .exc          (exc),
        .hw_int       (hw_int),
        .rf_raddr     (rf_raddr),
        .allowin      (allowin),
        .flush        (flush),
        .wb0          (wb0),
        .wb1          (wb1),
        .rf_rdata     (rf_rdata)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // val is the result, the mod/store select bit, or the csr address
    function automatic ex2_lane_t make_lane(input lane_op_e op, input logic [4:0] rd,
                                            input logic [31:0] val);
        ex2_lane_t ln;
        ln = '0;
        ln.valid = 1'b1;
        ln.rd = rd;
        case (op)
            op_alu: begin
                ln.result_valid = 1'b1;
                ln.result = val;
            end
            op_div: begin
                ln.uop.is_div = 1'b1;
                ln.uop.cond.div.mod_sel = val[0];
            end
            op_mem: begin
                ln.uop.is_mem = 1'b1;
                ln.uop.cond.mem.is_store = val[0];
            end
            default: begin
                ln.uop.is_csr = 1'b1;
                ln.uop.csr_addr = val[13:0];
            end
        endcase
        return ln;
    endfunction

    function automatic row_t blank_row();
        row_t r;
        r = '0;
        r.div_rdy = 1'b1;
        r.dc_rdy = 1'b1;
        r.exp_allowin = 1'b1;
        return r;
    endfunction

    task automatic add_row(input string name, input logic [4:0] rd, input logic [31:0] expv,
                           input logic [1:0] we);
        cur.chk_rd = rd;
        cur.exp_data = expv;
        cur.exp_we = we;
        rows.push_back(cur);
        names.push_back(name);
        cur = blank_row();
    endtask

    task automatic build_table();
        logic [31:0] rnd [0:13];
        for (int i = 0; i < 14; i++) begin
            rnd[i] = lcg_next();
        end
        cur.l0 = make_lane(op_alu, 5'd5, rnd[0]);
        cur.l1 = make_lane(op_alu, 5'd6, rnd[1]);
        add_row("alu_lane0", 5'd5, rnd[0], 2'b11);
        add_row("alu_lane1", 5'd6, rnd[1], 2'b00);
        cur.l0 = make_lane(op_alu, 5'd7, rnd[2]);
        cur.l1 = make_lane(op_alu, 5'd7, rnd[3]);
        add_row("same_rd", 5'd7, rnd[3], 2'b11);  // lane 1 wins
        cur.l0 = make_lane(op_div, 5'd8, 32'd1);
        cur.quo = rnd[4];
        cur.rem = rnd[5];
        add_row("div_rem", 5'd8, rnd[5], 2'b01);
        cur.l1 = make_lane(op_div, 5'd9, 32'd0);
        cur.quo = rnd[4];
        cur.rem = rnd[5];
        add_row("div_quo", 5'd9, rnd[4], 2'b10);
        cur.l0 = make_lane(op_div, 5'd8, 32'd0);
        cur.quo = rnd[6];
        cur.div_rdy = 1'b0;
        cur.exp_allowin = 1'b0;
        add_row("div_wait", 5'd8, rnd[5], 2'b00);
        cur.l0 = make_lane(op_mem, 5'd10, 32'd0);
        cur.dcd = rnd[6];
        add_row("load", 5'd10, rnd[6], 2'b01);
        cur.l1 = make_lane(op_mem, 5'd10, 32'd0);
        cur.dcd = rnd[7];
        cur.dc_rdy = 1'b0;
        cur.exp_allowin = 1'b0;
        add_row("load_wait", 5'd10, rnd[6], 2'b00);
        cur.l0 = make_lane(op_mem, 5'd10, 32'd1);
        cur.dcd = rnd[8];
        add_row("store", 5'd10, rnd[6], 2'b00);
        cur.l0 = make_lane(op_csr, 5'd11, {18'd0, csr_crmd_a});
        add_row("crmd_reset", 5'd11, 32'h4, 2'b01);  // ie at bit 2
        cur.l0 = make_lane(op_alu, 5'd0, rnd[9]);
        cur.hwi = 1'b1;
        cur.exc.era = rnd[9];
        cur.exp_flush = 1'b1;
        add_row("hw_int", 5'd0, 32'd0, 2'b01);
        cur.l0 = make_lane(op_csr, 5'd12, {18'd0, csr_era_a});
        add_row("era_int", 5'd12, rnd[9], 2'b01);
        cur.l0 = make_lane(op_csr, 5'd13, {18'd0, csr_crmd_a});
        add_row("crmd_ie_off", 5'd13, 32'd0, 2'b01);
        cur.l1 = make_lane(op_alu, 5'd0, rnd[10]);
        cur.exc = '{flag: 1'b1, ecode: exp_pis, badv: rnd[10], era: rnd[11]};
        cur.exp_flush = 1'b1;
        add_row("exc_page", 5'd0, 32'd0, 2'b10);
        cur.l0 = make_lane(op_csr, 5'd14, {18'd0, csr_badv_a});
        add_row("badv_page", 5'd14, rnd[10], 2'b01);
        cur.l0 = make_lane(op_csr, 5'd15, {18'd0, csr_era_a});
        add_row("era_page", 5'd15, rnd[11], 2'b01);
        cur.l0 = make_lane(op_csr, 5'd16, {18'd0, csr_tlbehi_a});
        add_row("tlbehi_page", 5'd16, {rnd[10][18:0], 13'd0}, 2'b01);
        cur.l1 = make_lane(op_alu, 5'd0, rnd[12]);
        cur.exc = '{flag: 1'b1, ecode: exp_sys, badv: rnd[12], era: rnd[13]};
        cur.exp_flush = 1'b1;
        add_row("exc_sys", 5'd0, 32'd0, 2'b10);
        cur.l0 = make_lane(op_csr, 5'd17, {18'd0, csr_era_a});
        add_row("era_sys", 5'd17, rnd[13], 2'b01);
        cur.l0 = make_lane(op_csr, 5'd18, {18'd0, csr_badv_a});
        add_row("badv_kept", 5'd18, rnd[10], 2'b01);
    endtask

    // drive one row then idle two cycles and read back
    task automatic run_row(input int i);
        row_t r;
        logic seen_flush;
        r = rows[i];
        lane0 = r.l0;
        lane1 = r.l1;
        quotient = r.quo;
        remainder = r.rem;
        dcache_data = r.dcd;
        div_ready = r.div_rdy;
        dcache_ready = r.dc_rdy;
        exc = r.exc;
        hw_int = r.hwi;
        rf_raddr = r.chk_rd;
        #1;
        checks++;
        if (allowin !== r.exp_allowin) begin
            errors++;
            $display("CHECK FAILED %s allowin: expected %0d, actual %0d",
                     names[i], r.exp_allowin, allowin);
        end
        @(negedge clk);
        seen_flush = flush;
        checks++;
        if ({wb1.we, wb0.we} !== r.exp_we) begin
            errors++;
            $display("CHECK FAILED %s wb we: expected %b, actual %b",
                     names[i], r.exp_we, {wb1.we, wb0.we});
        end
        lane0.valid = 1'b0;
        lane1.valid = 1'b0;
        exc.flag = 1'b0;  // era and badv stay for the interrupt path
        hw_int = 1'b0;
        @(negedge clk);
        seen_flush = seen_flush | flush;
        @(negedge clk);
        checks++;
        if (seen_flush !== r.exp_flush) begin
            errors++;
            $display("CHECK FAILED %s flush: expected %0d, actual %0d",
                     names[i], r.exp_flush, seen_flush);
        end
        checks++;
        if (rf_rdata !== r.exp_data) begin
            errors++;
            $display("CHECK FAILED %s r%0d: expected %h, actual %h",
                     names[i], r.chk_rd, r.exp_data, rf_rdata);
        end
    endtask

    initial begin
        wait (table_ready);
        repeat (5 + rows.size() * 4 + 20) @(posedge clk);
        $display("watchdog expired before all rows finished");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        clk = 1'b0;
        aresetn = 1'b0;
        lane0 = '0;
        lane1 = '0;
        quotient = '0;
        remainder = '0;
        div_ready = 1'b0;
        dcache_data = '0;
        dcache_ready = 1'b0;
        exc = '0;
        hw_int = 1'b0;
        rf_raddr = '0;
        errors = 0;
        checks = 0;
        lcg_state = 32'd58143;
        cur = blank_row();
        build_table();
        table_ready = 1'b1;
        repeat (5) @(negedge clk);
        aresetn = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("errors: %0d of %0d checks over %0d rows", errors, checks, rows.size());
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/wb_props.sv */
`default_nettype none

module wb_props import wb_pkg::*; (
    input logic        clk,
    input logic        aresetn,
    input ex2_lane_t   lane0,
    input ex2_lane_t   lane1,
    input logic        dcache_ready,
    input exc_info_t   exc,
    input logic        int_req,
    input logic        flush,
    input wb_t         wb0,
    input logic        allowin,
    input logic [4:0]  rf_raddr,
    input logic [31:0] rf_rdata
);

    function automatic logic waiting_load(input ex2_lane_t ln, input logic rdy);
        return ln.valid && ln.uop.is_mem && !ln.uop.cond.mem.is_store && !rdy;
    endfunction

    // pulse ended and no interrupt behind it
    flush_falls: assert property (@(posedge clk) disable iff (!aresetn)
        $past(exc.flag, 2) && !$past(exc.flag) && !$past(int_req) |-> !flush)
        else $error("flush stayed high after a one-cycle exception pulse");

    wb0_needs_valid: assert property (@(posedge clk) disable iff (!aresetn)
        !$past(lane0.valid) |-> !wb0.we)
        else $error("wb0.we set for an invalid lane 0");

    load_blocks: assert property (@(posedge clk) disable iff (!aresetn)
        waiting_load(lane0, dcache_ready) || waiting_load(lane1, dcache_ready) |-> !allowin)
        else $error("allowin high while a load waits on the dcache");

    r0_zero: assert property (@(posedge clk) disable iff (!aresetn)
        (rf_raddr == 5'd0) |-> (rf_rdata == 32'd0))
        else $error("register 0 reads nonzero");

endmodule

bind wb_top wb_props u_props (
    .clk          (clk),
    .aresetn      (aresetn),
    .lane0        (lane0),
    .lane1        (lane1),
    .dcache_ready (dcache_ready),
    .exc          (exc),
    .int_req      (int_req),
    .flush        (flush),
    .wb0          (wb0),
    .allowin      (allowin),
    .rf_raddr     (rf_raddr),
    .rf_rdata     (rf_rdata)
);

`default_nettype wire
